// ==== src/pad_input_cfg.svh ====
// Widths, button indices, controller type codes and register map; include where needed
`ifndef PAD_INPUT_CFG_SVH
`define PAD_INPUT_CFG_SVH

// ==============================
// Widths
// ==============================
`define PAD_BITS        12
`define LLAPI_BTN_BITS  32
`define LLAPI_TYPE_BITS 8
`define CFG_ADDR_BITS   2
`define CFG_DATA_BITS   8

// ==============================
// Controller types and buttons
// ==============================
// Saturn pads get their own L/R and select layout
`define SATURN_TYPE_A 8'd3
`define SATURN_TYPE_B 8'd8
// Unknown or absent controller
`define TYPE_EMPTY_LO 8'd0
`define TYPE_EMPTY_HI 8'd255
// Raw indices of the OSD combination
`define BTN_DOWN  26
`define BTN_START 5
`define BTN_FIRST 0

// ==============================
// Register map
// ==============================
`define CFG_ADDR_CTRL   2'd0
`define CTRL_SWAP_BIT   0
`define CTRL_SELECT_BIT 1

`endif

// ==== src/pad_input_pkg.sv ====
// Typedefs of the pad input design, referenced by scoped name from RTL and testbench
`include "pad_input_cfg.svh"

package pad_input_pkg;

	// Console pad word, MSB first
	// start, select, R, L, Y, X, B, A, then d-pad up, down, left, right
	typedef logic [`PAD_BITS-1:0] pad_word_t;

	// Raw adapter report, one bit per HID button id minus one
	typedef logic [`LLAPI_BTN_BITS-1:0] llapi_buttons_t;

	// Controller type reported by the adapter
	typedef logic [`LLAPI_TYPE_BITS-1:0] llapi_type_t;

	// ==============================
	// Configuration bus
	// ==============================
	typedef logic [`CFG_ADDR_BITS-1:0] cfg_addr_t;
	typedef logic [`CFG_DATA_BITS-1:0] cfg_data_t;

endpackage

// ==== src/llapi_pad_if.sv ====
// One adapter link: raw report in from the top, decoded pad out to the slot router
`timescale 1ns/1ps

interface llapi_pad_if;

	// Raw report, driven from top-level ports
	pad_input_pkg::llapi_buttons_t buttons;
	pad_input_pkg::llapi_type_t    ctrl_type;
	logic                          link_en;

	// Decoded result
	pad_input_pkg::pad_word_t pad;
	logic                     present;
	logic                     osd_hit;

	modport decoder (
		input  buttons,
		input  ctrl_type,
		input  link_en,
		output pad,
		output present,
		output osd_hit
	);

	// Router sees only the decoded side
	modport router (
		input pad,
		input present,
		input osd_hit
	);

endinterface

// ==== src/pad_cfg_regs.sv ====
// Control register with write strobe and readback; drives the swap and adapter-select levels
`timescale 1ns/1ps
`include "pad_input_cfg.svh"

module pad_cfg_regs (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cfg_wr,
	input  pad_input_pkg::cfg_addr_t cfg_addr,
	input  pad_input_pkg::cfg_data_t cfg_wdata,
	output pad_input_pkg::cfg_data_t cfg_rdata,
	output logic                     swap,
	output logic                     llapi_select
);

	pad_input_pkg::cfg_data_t ctrl_reg;

	// ==============================
	// Write side
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_reg <= '0;
		end else if (cfg_wr && (cfg_addr == `CFG_ADDR_CTRL)) begin
			ctrl_reg <= cfg_wdata;
		end
	end

	// ==============================
	// Readback
	// ==============================
	// Same-cycle read, unmapped addresses return zero
	always_comb begin
		cfg_rdata = '0;
		if (cfg_addr == `CFG_ADDR_CTRL) begin
			cfg_rdata = ctrl_reg;
		end
	end

	// Control bits out to router and decoders
	assign swap         = ctrl_reg[`CTRL_SWAP_BIT];
	assign llapi_select = ctrl_reg[`CTRL_SELECT_BIT];

	// Write strobe must be driven once out of reset
	a_cfg_wr_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(cfg_wr)
	) else $error("cfg_wr is unknown");

endmodule

// ==== src/llapi_pad_decode.sv ====
// Per-link adapter decode: button mapping, controller presence and OSD combination
`timescale 1ns/1ps
`include "pad_input_cfg.svh"

module llapi_pad_decode (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         llapi_select,
	llapi_pad_if.decoder link
);

	pad_input_pkg::llapi_buttons_t btn;
	pad_input_pkg::pad_word_t      mapped;
	logic                          pressed;
	logic                          type_known;
	logic                          saturn;

	assign btn = link.buttons;

	// ==============================
	// Button mapping
	// ==============================
	assign saturn = (link.ctrl_type == `SATURN_TYPE_A) ||
		(link.ctrl_type == `SATURN_TYPE_B);

	always_comb begin
		// Start, face buttons and d-pad sit at the same raw ids for every type
		mapped[11] = btn[`BTN_START];
		mapped[7]  = btn[2];
		mapped[6]  = btn[3];
		mapped[5]  = btn[`BTN_FIRST];
		mapped[4]  = btn[1];
		mapped[3]  = btn[27];
		mapped[2]  = btn[`BTN_DOWN];
		mapped[1]  = btn[25];
		mapped[0]  = btn[24];
		if (saturn) begin
			// Saturn has no select, so Z stands in
			mapped[10] = btn[6];
			// Either right shoulder counts as R
			mapped[9]  = btn[9] | btn[7];
			mapped[8]  = btn[8];
		end else begin
			mapped[10] = btn[4];
			mapped[9]  = btn[7];
			mapped[8]  = btn[6];
		end
	end

	assign link.pad = mapped;

	// ==============================
	// Presence detection
	// ==============================
	// Type 0 may be a plain pad or nothing at all; wait for a press to tell
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
		end else if (|btn) begin
			pressed <= 1'b1;
		end
	end

	assign type_known = (link.ctrl_type != `TYPE_EMPTY_LO) &&
		(link.ctrl_type != `TYPE_EMPTY_HI);

	assign link.present = link.link_en && llapi_select && (type_known || pressed);

	// OSD request works even while the adapter is deselected
	assign link.osd_hit = btn[`BTN_DOWN] & btn[`BTN_START] & btn[`BTN_FIRST];

	// A claimed slot is kept while enable, type and select hold
	a_present_holds: assert property (
		@(posedge clk_sys) disable iff (reset)
		$past(link.present) && $stable(link.link_en) && $stable(link.ctrl_type) &&
			$stable(llapi_select) |-> link.present
	) else $error("present dropped with unchanged link inputs");

endmodule

// ==== src/player_slot_router.sv ====
// Assigns adapter and USB pads to player slots, applies the 1/2 swap and registers outputs
`timescale 1ns/1ps

module player_slot_router (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     swap,
	llapi_pad_if.router              link_a,
	llapi_pad_if.router              link_b,
	input  pad_input_pkg::pad_word_t usb_pad0,
	input  pad_input_pkg::pad_word_t usb_pad1,
	input  pad_input_pkg::pad_word_t usb_pad2,
	input  pad_input_pkg::pad_word_t usb_pad3,
	input  pad_input_pkg::pad_word_t usb_pad4,
	output pad_input_pkg::pad_word_t joy0,
	output pad_input_pkg::pad_word_t joy1,
	output pad_input_pkg::pad_word_t joy2,
	output pad_input_pkg::pad_word_t joy3,
	output pad_input_pkg::pad_word_t joy4,
	output logic                     osd_btn
);

	pad_input_pkg::pad_word_t slot [5];
	pad_input_pkg::pad_word_t player1;
	pad_input_pkg::pad_word_t player2;
	logic                     osd_any;

	// ==============================
	// Slot assignment
	// ==============================
	// USB pads shift down past however many adapter pads are present
	always_comb begin
		if (link_a.present && link_b.present) begin
			slot[0] = link_a.pad;
			slot[1] = link_b.pad;
			slot[2] = usb_pad0;
			slot[3] = usb_pad1;
			slot[4] = usb_pad2;
		end else if (link_a.present || link_b.present) begin
			// usb0 fills whichever of the first two slots is free
			slot[0] = link_a.present ? link_a.pad : usb_pad0;
			slot[1] = link_b.present ? link_b.pad : usb_pad0;
			slot[2] = usb_pad1;
			slot[3] = usb_pad2;
			slot[4] = usb_pad3;
		end else begin
			slot[0] = usb_pad0;
			slot[1] = usb_pad1;
			slot[2] = usb_pad2;
			slot[3] = usb_pad3;
			slot[4] = usb_pad4;
		end
	end

	// Swap only touches players 1 and 2
	assign player1 = swap ? slot[1] : slot[0];
	assign player2 = swap ? slot[0] : slot[1];

	assign osd_any = link_a.osd_hit | link_b.osd_hit;

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy0    <= '0;
			joy1    <= '0;
			joy2    <= '0;
			joy3    <= '0;
			joy4    <= '0;
			osd_btn <= 1'b0;
		end else begin
			joy0    <= player1;
			joy1    <= player2;
			joy2    <= slot[2];
			joy3    <= slot[3];
			joy4    <= slot[4];
			osd_btn <= osd_any;
		end
	end

	// OSD request must be clean once both decoders run
	a_osd_btn_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(osd_btn)
	) else $error("osd_btn is unknown");

endmodule

// ==== src/pad_input_top.sv ====
// Top level of the controller input path: two adapter decoders, config registers, slot router
`timescale 1ns/1ps

module pad_input_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	// Configuration bus
	input  logic                          cfg_wr,
	input  pad_input_pkg::cfg_addr_t      cfg_addr,
	input  pad_input_pkg::cfg_data_t      cfg_wdata,
	output pad_input_pkg::cfg_data_t      cfg_rdata,
	// Adapter link A
	input  pad_input_pkg::llapi_buttons_t llapi_buttons_a,
	input  pad_input_pkg::llapi_type_t    llapi_type_a,
	input  logic                          llapi_en_a,
	// Adapter link B
	input  pad_input_pkg::llapi_buttons_t llapi_buttons_b,
	input  pad_input_pkg::llapi_type_t    llapi_type_b,
	input  logic                          llapi_en_b,
	// USB pads
	input  pad_input_pkg::pad_word_t      usb_pad0,
	input  pad_input_pkg::pad_word_t      usb_pad1,
	input  pad_input_pkg::pad_word_t      usb_pad2,
	input  pad_input_pkg::pad_word_t      usb_pad3,
	input  pad_input_pkg::pad_word_t      usb_pad4,
	// Console side
	output pad_input_pkg::pad_word_t      joy0,
	output pad_input_pkg::pad_word_t      joy1,
	output pad_input_pkg::pad_word_t      joy2,
	output pad_input_pkg::pad_word_t      joy3,
	output pad_input_pkg::pad_word_t      joy4,
	output logic                          osd_btn
);

	logic swap;
	logic llapi_select;

	llapi_pad_if link_a ();
	llapi_pad_if link_b ();

	// Raw reports onto the link interfaces
	assign link_a.buttons   = llapi_buttons_a;
	assign link_a.ctrl_type = llapi_type_a;
	assign link_a.link_en   = llapi_en_a;
	assign link_b.buttons   = llapi_buttons_b;
	assign link_b.ctrl_type = llapi_type_b;
	assign link_b.link_en   = llapi_en_b;

	pad_cfg_regs pad_cfg_regs_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.swap         (swap),
		.llapi_select (llapi_select)
	);

	llapi_pad_decode llapi_pad_decode_a_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.link         (link_a.decoder)
	);

	llapi_pad_decode llapi_pad_decode_b_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.link         (link_b.decoder)
	);

	player_slot_router player_slot_router_inst (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.swap     (swap),
		.link_a   (link_a.router),
		.link_b   (link_b.router),
		.usb_pad0 (usb_pad0),
		.usb_pad1 (usb_pad1),
		.usb_pad2 (usb_pad2),
		.usb_pad3 (usb_pad3),
		.usb_pad4 (usb_pad4),
		.joy0     (joy0),
		.joy1     (joy1),
		.joy2     (joy2),
		.joy3     (joy3),
		.joy4     (joy4),
		.osd_btn  (osd_btn)
	);

endmodule

// ==== tests/tb_pad_input.sv ====
// Testbench for pad_input_top; drives adapter, USB and config inputs and checks against a model
`timescale 1ns/1ps
`include "pad_input_cfg.svh"

module tb_pad_input;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS  = 6;
	localparam int STIM_COUNT = 16;
	localparam logic [31:0] OSD_COMBO = (32'h1 << `BTN_DOWN) | (32'h1 << `BTN_START) |
		(32'h1 << `BTN_FIRST);

	typedef struct packed {
		logic [4:0][`PAD_BITS-1:0] joy;
		logic                      osd;
	} expected_t;

	logic clk_sys = 1'b0;
	logic reset;
	logic cfg_wr;
	pad_input_pkg::cfg_addr_t      cfg_addr;
	pad_input_pkg::cfg_data_t      cfg_wdata;
	pad_input_pkg::cfg_data_t      cfg_rdata;
	pad_input_pkg::llapi_buttons_t llapi_buttons_a;
	pad_input_pkg::llapi_buttons_t llapi_buttons_b;
	pad_input_pkg::llapi_type_t    llapi_type_a;
	pad_input_pkg::llapi_type_t    llapi_type_b;
	logic                          llapi_en_a;
	logic                          llapi_en_b;
	pad_input_pkg::pad_word_t      usb_pad0, usb_pad1, usb_pad2, usb_pad3, usb_pad4;
	pad_input_pkg::pad_word_t      joy0, joy1, joy2, joy3, joy4;
	logic                          osd_btn;

	// Model of the control register and pressed latches
	pad_input_pkg::cfg_data_t model_ctrl;
	logic      pressed_a;
	logic      pressed_b;
	expected_t want;
	integer    seed;
	int        error_count;
	int        check_count;
	int        test_errors;
	int        tests_passed;
	int        tests_failed;
	event      check_ev;
	event      check_done;

	pad_input_top pad_input_top_inst (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==============================
	// Reference model
	// ==============================
	function automatic pad_input_pkg::pad_word_t map_report(
		input pad_input_pkg::llapi_buttons_t b, input pad_input_pkg::llapi_type_t t);
		logic sat;
		sat = (t == `SATURN_TYPE_A) || (t == `SATURN_TYPE_B);
		return {b[5], sat ? b[6] : b[4], sat ? (b[9] | b[7]) : b[7], sat ? b[8] : b[6],
			b[2], b[3], b[0], b[1], b[27], b[26], b[25], b[24]};
	endfunction

	function automatic logic link_present(input logic en, input pad_input_pkg::llapi_type_t t,
		input logic pressed);
		return en && model_ctrl[`CTRL_SELECT_BIT] &&
			(((t != `TYPE_EMPTY_LO) && (t != `TYPE_EMPTY_HI)) || pressed);
	endfunction

	function automatic expected_t expected_outputs();
		expected_t e;
		logic pa;
		logic pb;
		logic [`PAD_BITS-1:0] tmp;
		pa = link_present(llapi_en_a, llapi_type_a, pressed_a);
		pb = link_present(llapi_en_b, llapi_type_b, pressed_b);
		if (pa && pb) begin
			e.joy = {usb_pad2, usb_pad1, usb_pad0, map_report(llapi_buttons_b, llapi_type_b),
				map_report(llapi_buttons_a, llapi_type_a)};
		end else if (pa || pb) begin
			e.joy[0] = pa ? map_report(llapi_buttons_a, llapi_type_a) : usb_pad0;
			e.joy[1] = pb ? map_report(llapi_buttons_b, llapi_type_b) : usb_pad0;
			e.joy[4:2] = {usb_pad3, usb_pad2, usb_pad1};
		end else begin
			e.joy = {usb_pad4, usb_pad3, usb_pad2, usb_pad1, usb_pad0};
		end
		if (model_ctrl[`CTRL_SWAP_BIT]) begin
			tmp = e.joy[0];
			e.joy[0] = e.joy[1];
			e.joy[1] = tmp;
		end
		e.osd = ((llapi_buttons_a & OSD_COMBO) == OSD_COMBO) ||
			((llapi_buttons_b & OSD_COMBO) == OSD_COMBO);
		return e;
	endfunction

	// ==============================
	// Checking
	// ==============================
	task automatic check_value(input string name, input logic [`PAD_BITS-1:0] expected,
		input logic [`PAD_BITS-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected,
				actual);
		end
	endtask

	// Compares all console outputs on the falling edge after a request
	always begin
		@(check_ev);
		@(negedge clk_sys);
		want = expected_outputs();
		check_value("joy0", want.joy[0], joy0);
		check_value("joy1", want.joy[1], joy1);
		check_value("joy2", want.joy[2], joy2);
		check_value("joy3", want.joy[3], joy3);
		check_value("joy4", want.joy[4], joy4);
		check_value("osd_btn", {11'd0, want.osd}, {11'd0, osd_btn});
		-> check_done;
	end

	// Two edges for latch and router register plus one spare
	task automatic settle_and_check();
		if (|llapi_buttons_a) pressed_a = 1'b1;
		if (|llapi_buttons_b) pressed_b = 1'b1;
		repeat (3) @(posedge clk_sys);
		-> check_ev;
		@(check_done);
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic apply_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		cfg_wr = 1'b0;
		{llapi_buttons_a, llapi_buttons_b, llapi_type_a, llapi_type_b} = '0;
		{llapi_en_a, llapi_en_b} = 2'b00;
		{usb_pad0, usb_pad1, usb_pad2, usb_pad3, usb_pad4} = '0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		model_ctrl = '0;
		pressed_a = 1'b0;
		pressed_b = 1'b0;
	endtask

	task automatic write_ctrl(input pad_input_pkg::cfg_data_t data);
		cfg_wr = 1'b1;
		cfg_addr = `CFG_ADDR_CTRL;
		cfg_wdata = data;
		@(negedge clk_sys);
		cfg_wr = 1'b0;
		model_ctrl = data;
	endtask

	task automatic check_readback(input pad_input_pkg::cfg_addr_t addr,
		input pad_input_pkg::cfg_data_t expected);
		cfg_addr = addr;
		#1;
		check_value("cfg_rdata", {4'd0, expected}, {4'd0, cfg_rdata});
		@(negedge clk_sys);
	endtask

	task automatic randomize_usb();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = rand32();
		r1 = rand32();
		usb_pad0 = r0[11:0];
		usb_pad1 = r0[23:12];
		usb_pad2 = r1[11:0];
		usb_pad3 = r1[23:12];
		usb_pad4 = {r0[31:24], r1[31:28]};
	endtask

	task automatic start_test();
		test_errors = error_count;
		apply_reset();
	endtask

	task automatic finish_test(input int num, input string name);
		if (error_count == test_errors) begin
			tests_passed++;
			$display("Test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", num, name, error_count - test_errors);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		logic [31:0] r;
		seed = 31771;
		{error_count, check_count, tests_passed, tests_failed} = '0;
		reset = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		{llapi_buttons_a, llapi_buttons_b, llapi_type_a, llapi_type_b} = '0;
		{llapi_en_a, llapi_en_b} = 2'b00;
		{usb_pad0, usb_pad1, usb_pad2, usb_pad3, usb_pad4} = '0;

		start_test();
		settle_and_check();
		check_readback(`CFG_ADDR_CTRL, 8'h00);
		write_ctrl(8'hA5);
		check_readback(`CFG_ADDR_CTRL, 8'hA5);
		check_readback(2'd1, 8'h00);
		check_readback(2'd2, 8'h00);
		check_readback(2'd3, 8'h00);
		finish_test(1, "reset and register readback");

		start_test();
		for (int i = 0; i < STIM_COUNT; i++) begin
			randomize_usb();
			r = rand32();
			{llapi_type_a, llapi_type_b, llapi_en_a, llapi_en_b} = r[17:0];
			llapi_buttons_a = rand32();
			llapi_buttons_b = rand32();
			settle_and_check();
		end
		finish_test(2, "adapter deselected");

		start_test();
		write_ctrl(8'h02);
		{llapi_en_a, llapi_en_b} = 2'b11;
		for (int i = 0; i < STIM_COUNT; i++) begin
			randomize_usb();
			llapi_type_a = (i % 2 == 0) ? `SATURN_TYPE_A : 8'd1;
			llapi_type_b = (i % 4 < 2) ? `SATURN_TYPE_B : 8'd5;
			llapi_buttons_a = rand32();
			llapi_buttons_b = rand32();
			settle_and_check();
		end
		finish_test(3, "two typed adapters");

		// Link A with type 0, then link B with type 0 after a fresh reset
		start_test();
		for (int side = 0; side < 2; side++) begin
			if (side == 1) apply_reset();
			write_ctrl(8'h02);
			llapi_en_a = (side == 0);
			llapi_en_b = (side == 1);
			llapi_type_a = (side == 0) ? 8'd0 : 8'd1;
			llapi_type_b = (side == 1) ? 8'd0 : 8'd1;
			randomize_usb();
			settle_and_check();
			for (int i = 0; i < 4; i++) begin
				randomize_usb();
				r = (i == 3) ? 32'h0 : (rand32() | 32'h1);
				if (side == 0) llapi_buttons_a = r;
				else llapi_buttons_b = r;
				settle_and_check();
			end
		end
		finish_test(4, "untyped adapter and one-link shift");

		start_test();
		write_ctrl(8'h03);
		llapi_type_a = 8'd5;
		llapi_type_b = `SATURN_TYPE_A;
		for (int i = 0; i < STIM_COUNT; i++) begin
			randomize_usb();
			{llapi_en_a, llapi_en_b} = 2'(i % 4);
			llapi_buttons_a = rand32();
			llapi_buttons_b = rand32();
			settle_and_check();
		end
		finish_test(5, "player swap");

		start_test();
		for (int i = 0; i < 8; i++) begin
			randomize_usb();
			r = rand32() | OSD_COMBO;
			case (i)
				0: {llapi_buttons_a, llapi_buttons_b} = {OSD_COMBO, 32'h0};
				1: {llapi_buttons_a, llapi_buttons_b} = {32'h0, OSD_COMBO};
				2: {llapi_buttons_a, llapi_buttons_b} = {r, 32'h0};
				3: llapi_buttons_a = OSD_COMBO & ~(32'h1 << `BTN_DOWN);
				4: llapi_buttons_a = OSD_COMBO & ~(32'h1 << `BTN_START);
				5: llapi_buttons_a = OSD_COMBO & ~(32'h1 << `BTN_FIRST);
				6: {llapi_buttons_a, llapi_buttons_b} = {32'h0, r & ~(32'h1 << `BTN_START)};
				default: {llapi_buttons_a, llapi_buttons_b} = '0;
			endcase
			settle_and_check();
		end
		finish_test(6, "OSD combination");

		$display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d", tests_passed,
			tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog sized from test count and stimulus length
	initial begin
		#(NUM_TESTS * STIM_COUNT * 20 * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the expected time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/pad_input_pkg.sv
src/llapi_pad_if.sv
src/pad_cfg_regs.sv
src/llapi_pad_decode.sv
src/player_slot_router.sv
src/pad_input_top.sv
tests/tb_pad_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pad input testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_pad_input --Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pad_input)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
